//--- src.f
+incdir+include
rtl/rob_pkg.sv
rtl/cdb_pkg.sv
rtl/rob_dispatch.sv
rtl/rob_entry.sv
rtl/rob_retire.sv
rtl/rob_top.sv
verif/rob_checker.sv
verif/rob_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the ROB testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module rob_tb -o rob_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/rob_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
	exit 1
fi
if ! grep -q '\*\* PASS \*\*' "$LOG"; then
	echo "no pass line in $LOG"
	exit 1
fi
exit 0

//--- verif/rob_tb.sv
`include "rob_consts.svh"

module rob_tb;
	import rob_pkg::*;
	import cdb_pkg::*;

	logic clock;
	logic rst_n;
	logic [`SS_WIDTH-1:0] dispatch_en;
	preg_t disp_t_new [`SS_WIDTH];
	preg_t disp_t_old [`SS_WIDTH];
	areg_t disp_areg [`SS_WIDTH];
	op_kind_t disp_kind [`SS_WIDTH];
	logic [`SS_WIDTH-1:0] cdb_valid;
	preg_t cdb_tag [`SS_WIDTH];
	logic [`SS_WIDTH-1:0] cdb_mispredict;
	rob_cnt_t free_rows;
	logic full;
	logic [`SS_WIDTH-1:0] retire_valid;
	preg_t retire_t_old [`SS_WIDTH];
	preg_t retire_t_new [`SS_WIDTH];
	areg_t retire_areg [`SS_WIDTH];
	op_kind_t retire_kind [`SS_WIDTH];
	logic flush;
	logic halted;
	int errors;

	// Stimulus knobs set by each phase
	logic [1:0] want_en;
	op_kind_t want_kind [`SS_WIDTH];
	int cdb_rate; // Percent chance per CDB lane
	int misp_rate;
	preg_t next_tag;
	preg_t pend_tag [$]; // Tags of rows still waiting
	logic pend_br [$];
	int timeouts;
	int failed_tests;
	int last_bad;

	rob_top rob_top_i (.*);
	rob_checker checker_i (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic tick();
		int k;
		logic acc0;
		logic acc1;
		@(posedge clock);
		if (!rst_n || flush) begin
			pend_tag.delete();
			pend_br.delete();
		end else begin
			acc0 = dispatch_en[0] && free_rows >= 1;
			acc1 = acc0 && dispatch_en[1] && free_rows >= 2;
			if (acc0 && disp_kind[0] != op_halt) begin
				pend_tag.push_back(disp_t_new[0]);
				pend_br.push_back(disp_kind[0] == op_branch);
			end
			if (acc1 && disp_kind[1] != op_halt) begin
				pend_tag.push_back(disp_t_new[1]);
				pend_br.push_back(disp_kind[1] == op_branch);
			end
			next_tag = next_tag + preg_t'(acc0) + preg_t'(acc1); // In-flight tags stay unique
		end
		dispatch_en <= want_en;
		for (int l = 0; l < `SS_WIDTH; l++) begin
			disp_t_new[l] <= next_tag + preg_t'(l);
			disp_t_old[l] <= preg_t'($urandom);
			disp_areg[l]  <= areg_t'($urandom);
			disp_kind[l]  <= want_kind[l];
			if (pend_tag.size() > 0 && $urandom_range(99) < cdb_rate) begin
				k = $urandom_range(pend_tag.size() - 1);
				cdb_valid[l]      <= 1'b1;
				cdb_tag[l]        <= pend_tag[k];
				cdb_mispredict[l] <= pend_br[k] && ($urandom_range(99) < misp_rate);
				pend_tag.delete(k);
				pend_br.delete(k);
			end else begin
				cdb_valid[l]      <= 1'b0;
				cdb_mispredict[l] <= 1'b0;
			end
		end
	endtask

	task automatic apply_reset();
		rst_n <= 1'b0;
		want_en = 2'b00;
		cdb_rate = 0;
		repeat (5) tick();
		rst_n <= 1'b1;
		tick();
	endtask

	// 0 drained, 1 flush seen, 2 halted, 3 full, 4 drained or halted
	task automatic wait_until(int what, int limit, string desc);
		int n;
		n = 0;
		while (n < limit && !((what == 0 && free_rows == rob_cnt_t'(`ROB_SIZE))
			|| (what == 1 && flush) || (what == 2 && halted) || (what == 3 && full)
			|| (what == 4 && (halted || free_rows == rob_cnt_t'(`ROB_SIZE))))) begin
			tick();
			n++;
		end
		if (n >= limit) begin
			timeouts++;
			$display("timeout: %s did not happen within %0d cycles", desc, limit);
		end
	endtask

	task automatic end_phase(string name);
		int bad;
		bad = errors + timeouts - last_bad;
		last_bad = errors + timeouts;
		if (bad != 0)
			failed_tests++;
		$display("test %s: %s (%0d problems)", name, bad == 0 ? "ok" : "failed", bad);
	endtask

	initial begin
		int r;
		void'($urandom(32'ha8b7_562e));
		rst_n = 1'b0;
		dispatch_en = '0;
		cdb_valid = '0;
		cdb_mispredict = '0;
		for (int l = 0; l < `SS_WIDTH; l++) begin
			disp_t_new[l] = '0;
			disp_t_old[l] = '0;
			disp_areg[l] = '0;
			disp_kind[l] = op_alu;
			cdb_tag[l] = '0;
			want_kind[l] = op_alu;
		end
		want_en = '0;
		cdb_rate = 0;
		misp_rate = 0;
		next_tag = '0;
		timeouts = 0;
		failed_tests = 0;
		last_bad = 0;

		apply_reset();
		repeat (3) tick();
		end_phase("reset values");

		want_en = 2'b11; // Eight ALU ops, then complete in random order
		repeat (4) tick();
		want_en = 2'b00;
		cdb_rate = 60;
		wait_until(0, 200, "drain after ALU ops");
		end_phase("in-order retire");

		cdb_rate = 0;
		repeat (6) begin
			want_en = 2'($urandom_range(3));
			tick();
		end
		want_en = 2'b11;
		wait_until(3, 50, "full");
		want_en = 2'b00;
		cdb_rate = 50;
		wait_until(0, 200, "drain after full");
		end_phase("acceptance and full");

		cdb_rate = 0;
		want_en = 2'b01;
		want_kind[0] = op_branch;
		tick();
		want_kind[0] = op_alu;
		want_en = 2'b11;
		repeat (2) tick();
		want_en = 2'b00;
		cdb_rate = 100;
		misp_rate = 100;
		wait_until(1, 100, "flush");
		repeat (2) tick();
		misp_rate = 0;
		end_phase("mispredict flush");

		cdb_rate = 0;
		want_en = 2'b11;
		tick();
		want_kind[1] = op_halt;
		tick();
		want_kind[1] = op_alu;
		repeat (3) tick(); // Rows behind the halt
		want_en = 2'b00;
		cdb_rate = 100;
		wait_until(2, 100, "halted");
		repeat (10) tick();
		end_phase("halt");
		apply_reset();

		cdb_rate = 50;
		misp_rate = 10;
		repeat (2000) begin
			want_en = 2'($urandom_range(3));
			for (int l = 0; l < `SS_WIDTH; l++) begin
				r = $urandom_range(99);
				want_kind[l] = r < 70 ? op_alu : (r < 97 ? op_branch : op_halt);
			end
			tick();
			if (halted)
				apply_reset();
		end
		want_en = 2'b00;
		misp_rate = 0;
		cdb_rate = 100;
		if (halted)
			apply_reset();
		wait_until(4, 200, "final drain"); // A halt still in flight may stop the drain
		end_phase("random mix");

		$display("tests 6, failed %0d, errors %0d, timeouts %0d",
			failed_tests, errors, timeouts);
		if (errors == 0 && timeouts == 0 && failed_tests == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- verif/rob_checker.sv
`include "rob_consts.svh"

module rob_checker (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic [`SS_WIDTH-1:0]    dispatch_en,
	input  cdb_pkg::preg_t          disp_t_new [`SS_WIDTH],
	input  cdb_pkg::preg_t          disp_t_old [`SS_WIDTH],
	input  cdb_pkg::areg_t          disp_areg [`SS_WIDTH],
	input  cdb_pkg::op_kind_t       disp_kind [`SS_WIDTH],
	input  logic [`SS_WIDTH-1:0]    cdb_valid,
	input  cdb_pkg::preg_t          cdb_tag [`SS_WIDTH],
	input  logic [`SS_WIDTH-1:0]    cdb_mispredict,
	input  rob_pkg::rob_cnt_t       free_rows,
	input  logic                    full,
	input  logic [`SS_WIDTH-1:0]    retire_valid,
	input  cdb_pkg::preg_t          retire_t_old [`SS_WIDTH],
	input  cdb_pkg::preg_t          retire_t_new [`SS_WIDTH],
	input  cdb_pkg::areg_t          retire_areg [`SS_WIDTH],
	input  cdb_pkg::op_kind_t       retire_kind [`SS_WIDTH],
	input  logic                    flush,
	input  logic                    halted,
	output int                      errors
);
	import rob_pkg::*;
	import cdb_pkg::*;

	typedef struct {
		preg_t    t_old;
		preg_t    t_new;
		areg_t    areg;
		op_kind_t kind;
		logic     done;
		logic     misp;
	} row_t;

	row_t q [$]; // Oldest row at index 0
	logic halted_m;

	initial errors = 0;

	task automatic compare(string name, logic [31:0] exp, logic [31:0] got);
		if (exp !== got) begin
			errors++;
			$display("error %s expected %h got %h", name, exp, got);
		end
	endtask

	function automatic logic ends_stream(row_t r);
		return (r.kind == op_halt) || (r.kind == op_branch && r.misp);
	endfunction

	always @(posedge clock) begin : model
		int free;
		logic [1:0] rv;
		logic bad;
		logic acc0;
		logic acc1;
		row_t nr;
		if (!rst_n) begin
			q.delete();
			halted_m = 1'b0;
		end else begin
			free = `ROB_SIZE - q.size();
			rv = 2'b00;
			if (!halted_m && q.size() >= 1 && q[0].done)
				rv[0] = 1'b1;
			if (rv[0] && !ends_stream(q[0]) && q.size() >= 2 && q[1].done)
				rv[1] = 1'b1;
			bad = (rv[0] && q[0].kind == op_branch && q[0].misp)
				|| (rv[1] && q[1].kind == op_branch && q[1].misp);

			compare("free_rows", free, free_rows);
			compare("full", free == 0, full);
			compare("retire_valid", rv, retire_valid);
			compare("flush", bad, flush);
			compare("halted", halted_m, halted);
			for (int l = 0; l < `SS_WIDTH; l++) begin
				if (rv[l]) begin
					compare($sformatf("retire_t_old[%0d]", l), q[l].t_old, retire_t_old[l]);
					compare($sformatf("retire_t_new[%0d]", l), q[l].t_new, retire_t_new[l]);
					compare($sformatf("retire_areg[%0d]", l), q[l].areg, retire_areg[l]);
					compare($sformatf("retire_kind[%0d]", l), q[l].kind, retire_kind[l]);
				end
			end

			// Completions only touch waiting rows, lane 0 wins
			foreach (q[i]) begin
				if (!q[i].done) begin
					if (cdb_valid[0] && cdb_tag[0] == q[i].t_new) begin
						q[i].done = 1'b1;
						q[i].misp = cdb_mispredict[0];
					end else if (cdb_valid[1] && cdb_tag[1] == q[i].t_new) begin
						q[i].done = 1'b1;
						q[i].misp = cdb_mispredict[1];
					end
				end
			end

			for (int l = 0; l < `SS_WIDTH; l++)
				if (rv[l] && q[l].kind == op_halt)
					halted_m = 1'b1;
			if (rv[1])
				void'(q.pop_front());
			if (rv[0])
				void'(q.pop_front());

			if (bad) begin
				q.delete(); // Dispatch in the flush cycle is lost too
			end else begin
				acc0 = dispatch_en[0] && free >= 1;
				acc1 = acc0 && dispatch_en[1] && free >= 2;
				for (int l = 0; l < `SS_WIDTH; l++) begin
					if ((l == 0 && acc0) || (l == 1 && acc1)) begin
						nr.t_old = disp_t_old[l];
						nr.t_new = disp_t_new[l];
						nr.areg  = disp_areg[l];
						nr.kind  = disp_kind[l];
						nr.done  = (disp_kind[l] == op_halt);
						nr.misp  = 1'b0;
						q.push_back(nr);
					end
				end
			end
		end
	end

endmodule

//--- rtl/rob_top.sv
`include "rob_consts.svh"

module rob_top (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic [`SS_WIDTH-1:0]    dispatch_en,
	input  cdb_pkg::preg_t          disp_t_new [`SS_WIDTH],
	input  cdb_pkg::preg_t          disp_t_old [`SS_WIDTH],
	input  cdb_pkg::areg_t          disp_areg [`SS_WIDTH],
	input  cdb_pkg::op_kind_t       disp_kind [`SS_WIDTH],
	input  logic [`SS_WIDTH-1:0]    cdb_valid,
	input  cdb_pkg::preg_t          cdb_tag [`SS_WIDTH],
	input  logic [`SS_WIDTH-1:0]    cdb_mispredict,
	output rob_pkg::rob_cnt_t       free_rows,
	output logic                    full,
	output logic [`SS_WIDTH-1:0]    retire_valid,
	output cdb_pkg::preg_t          retire_t_old [`SS_WIDTH],
	output cdb_pkg::preg_t          retire_t_new [`SS_WIDTH],
	output cdb_pkg::areg_t          retire_areg [`SS_WIDTH],
	output cdb_pkg::op_kind_t       retire_kind [`SS_WIDTH],
	output logic                    flush,
	output logic                    halted
);
	import rob_pkg::*;
	import cdb_pkg::*;

	logic [`ROB_SIZE-1:0] alloc;
	logic [`ROB_SIZE-1:0] alloc_lane;
	logic [`ROB_SIZE-1:0] release_row;
	logic [1:0]           retire_count;

	// Row contents seen by retire
	entry_state_t         row_state [`ROB_SIZE];
	preg_t                row_t_old [`ROB_SIZE];
	preg_t                row_t_new [`ROB_SIZE];
	areg_t                row_areg [`ROB_SIZE];
	op_kind_t             row_kind [`ROB_SIZE];
	logic [`ROB_SIZE-1:0] row_mispredict;

	rob_dispatch dispatch_i (
		.clock        (clock),
		.rst_n        (rst_n),
		.dispatch_en  (dispatch_en),
		.retire_count (retire_count),
		.flush        (flush),
		.alloc        (alloc),
		.alloc_lane   (alloc_lane),
		.free_rows    (free_rows),
		.full         (full)
	);

	for (genvar g = 0; g < `ROB_SIZE; g++) begin : g_row
		rob_entry entry_i (
			.clock          (clock),
			.rst_n          (rst_n),
			.alloc          (alloc[g]),
			.alloc_lane     (alloc_lane[g]),
			.disp_t_new     (disp_t_new),
			.disp_t_old     (disp_t_old),
			.disp_areg      (disp_areg),
			.disp_kind      (disp_kind),
			.cdb_valid      (cdb_valid),
			.cdb_tag        (cdb_tag),
			.cdb_mispredict (cdb_mispredict),
			.release_row    (release_row[g]),
			.flush          (flush),
			.state          (row_state[g]),
			.t_old          (row_t_old[g]),
			.t_new          (row_t_new[g]),
			.areg           (row_areg[g]),
			.kind           (row_kind[g]),
			.mispredict     (row_mispredict[g])
		);
	end

	rob_retire retire_i (
		.clock        (clock),
		.rst_n        (rst_n),
		.state        (row_state),
		.t_old        (row_t_old),
		.t_new        (row_t_new),
		.areg         (row_areg),
		.kind         (row_kind),
		.mispredict   (row_mispredict),
		.release_row  (release_row),
		.retire_count (retire_count),
		.flush        (flush),
		.halted       (halted),
		.retire_valid (retire_valid),
		.retire_t_old (retire_t_old),
		.retire_t_new (retire_t_new),
		.retire_areg  (retire_areg),
		.retire_kind  (retire_kind)
	);

endmodule

//--- rtl/rob_retire.sv
`include "rob_consts.svh"

module rob_retire (
	input  logic                    clock,
	input  logic                    rst_n,
	input  rob_pkg::entry_state_t   state [`ROB_SIZE],
	input  cdb_pkg::preg_t          t_old [`ROB_SIZE],
	input  cdb_pkg::preg_t          t_new [`ROB_SIZE],
	input  cdb_pkg::areg_t          areg [`ROB_SIZE],
	input  cdb_pkg::op_kind_t       kind [`ROB_SIZE],
	input  logic [`ROB_SIZE-1:0]    mispredict,
	output logic [`ROB_SIZE-1:0]    release_row,
	output logic [1:0]              retire_count,
	output logic                    flush,
	output logic                    halted,
	output logic [`SS_WIDTH-1:0]    retire_valid,
	output cdb_pkg::preg_t          retire_t_old [`SS_WIDTH],
	output cdb_pkg::preg_t          retire_t_new [`SS_WIDTH],
	output cdb_pkg::areg_t          retire_areg [`SS_WIDTH],
	output cdb_pkg::op_kind_t       retire_kind [`SS_WIDTH]
);
	import rob_pkg::*;
	import cdb_pkg::*;

	rob_idx_t head;
	rob_idx_t idx [`SS_WIDTH];
	logic [`SS_WIDTH-1:0] is_bad_br;
	logic [`SS_WIDTH-1:0] is_halt;
	logic halt_retire;

	assign idx[0] = head;
	assign idx[1] = head + rob_idx_t'(1);

	// Lane view of the two oldest rows
	always_comb begin
		for (int l = 0; l < `SS_WIDTH; l++) begin
			retire_t_old[l] = t_old[idx[l]];
			retire_t_new[l] = t_new[idx[l]];
			retire_areg[l]  = areg[idx[l]];
			retire_kind[l]  = kind[idx[l]];
			is_bad_br[l]    = (kind[idx[l]] == op_branch) && mispredict[idx[l]];
			is_halt[l]      = (kind[idx[l]] == op_halt);
		end
	end

	// Lane 1 only follows a lane 0 that does not end the stream
	assign retire_valid[0] = !halted && (state[idx[0]] == st_done);
	assign retire_valid[1] = retire_valid[0] && !is_bad_br[0] && !is_halt[0]
		&& (state[idx[1]] == st_done);

	assign flush        = |(retire_valid & is_bad_br);
	assign halt_retire  = |(retire_valid & is_halt);
	assign retire_count = {1'b0, retire_valid[0]} + {1'b0, retire_valid[1]};

	always_comb begin
		for (int r = 0; r < `ROB_SIZE; r++)
			release_row[r] = (retire_valid[0] && rob_idx_t'(r) == idx[0])
				|| (retire_valid[1] && rob_idx_t'(r) == idx[1]);
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			head   <= '0;
			halted <= 1'b0;
		end else begin
			if (flush)
				head <= '0; // Restart with the tail
			else
				head <= head + rob_idx_t'(retire_count);
			if (halt_retire)
				halted <= 1'b1; // Sticky until reset
		end
	end

	// Head row is empty right after a flush
	a_flush_clears: assert property (@(posedge clock) disable iff (!rst_n)
		flush |=> state[head] == st_free)
		else $error("ROB head row still busy after flush");

endmodule

//--- rtl/rob_entry.sv
`include "rob_consts.svh"

module rob_entry (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    alloc,
	input  logic                    alloc_lane,
	input  cdb_pkg::preg_t          disp_t_new [`SS_WIDTH],
	input  cdb_pkg::preg_t          disp_t_old [`SS_WIDTH],
	input  cdb_pkg::areg_t          disp_areg [`SS_WIDTH],
	input  cdb_pkg::op_kind_t       disp_kind [`SS_WIDTH],
	input  logic [`SS_WIDTH-1:0]    cdb_valid,
	input  cdb_pkg::preg_t          cdb_tag [`SS_WIDTH],
	input  logic [`SS_WIDTH-1:0]    cdb_mispredict,
	input  logic                    release_row,
	input  logic                    flush,
	output rob_pkg::entry_state_t   state,
	output cdb_pkg::preg_t          t_old,
	output cdb_pkg::preg_t          t_new,
	output cdb_pkg::areg_t          areg,
	output cdb_pkg::op_kind_t       kind,
	output logic                    mispredict
);
	import rob_pkg::*;
	import cdb_pkg::*;

	logic [`SS_WIDTH-1:0] match;
	logic hit;
	logic hit_mispredict;

	// Tag compare on both CDB lanes
	always_comb begin
		for (int l = 0; l < `SS_WIDTH; l++)
			match[l] = cdb_valid[l] && (cdb_tag[l] == t_new);
	end

	assign hit            = (state == st_wait) && (|match);
	assign hit_mispredict = match[0] ? cdb_mispredict[0] : cdb_mispredict[1];

	always_ff @(posedge clock) begin
		if (!rst_n)
			state <= st_free;
		else if (flush)
			state <= st_free;
		else if (alloc)
			state <= (disp_kind[alloc_lane] == op_halt) ? st_done : st_wait; // Halt needs no CDB
		else if (release_row)
			state <= st_free;
		else if (hit)
			state <= st_done;
	end

	// Row payload
	always_ff @(posedge clock) begin
		if (alloc) begin
			t_old      <= disp_t_old[alloc_lane];
			t_new      <= disp_t_new[alloc_lane];
			areg       <= disp_areg[alloc_lane];
			kind       <= disp_kind[alloc_lane];
			mispredict <= 1'b0;
		end else if (hit) begin
			mispredict <= hit_mispredict;
		end
	end

	// Dispatch bookkeeping must only hand out empty rows
	a_alloc_free: assert property (@(posedge clock) disable iff (!rst_n)
		alloc |-> state == st_free)
		else $error("ROB row allocated while busy");

endmodule

//--- rtl/rob_dispatch.sv
`include "rob_consts.svh"

module rob_dispatch (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic [`SS_WIDTH-1:0]    dispatch_en,
	input  logic [1:0]              retire_count,
	input  logic                    flush,
	output logic [`ROB_SIZE-1:0]    alloc,
	output logic [`ROB_SIZE-1:0]    alloc_lane,
	output rob_pkg::rob_cnt_t       free_rows,
	output logic                    full
);
	import rob_pkg::*;

	rob_idx_t tail;
	rob_idx_t tail_plus1;
	rob_cnt_t count;
	rob_cnt_t n_acc;
	logic [`SS_WIDTH-1:0] accept;

	assign free_rows = rob_cnt_t'(`ROB_SIZE) - count;
	assign full      = (count == rob_cnt_t'(`ROB_SIZE));

	// Lanes go in order, a younger lane never passes a dropped older one
	assign accept[0] = dispatch_en[0] && !flush && (free_rows >= rob_cnt_t'(1));
	assign accept[1] = accept[0] && dispatch_en[1] && (free_rows >= rob_cnt_t'(2));
	assign n_acc     = rob_cnt_t'(accept[0]) + rob_cnt_t'(accept[1]);

	assign tail_plus1 = tail + rob_idx_t'(1);

	// One-hot row strobes from the tail
	always_comb begin
		for (int r = 0; r < `ROB_SIZE; r++) begin
			alloc[r]      = (accept[0] && rob_idx_t'(r) == tail)
				|| (accept[1] && rob_idx_t'(r) == tail_plus1);
			alloc_lane[r] = accept[1] && rob_idx_t'(r) == tail_plus1; // Lane 1 takes tail+1
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			tail  <= '0;
			count <= '0;
		end else if (flush) begin
			tail  <= '0; // Whole buffer emptied
			count <= '0;
		end else begin
			tail  <= tail + rob_idx_t'(n_acc);
			count <= count + n_acc - rob_cnt_t'(retire_count);
		end
	end

	// Retire never drains more rows than the tail has handed out
	a_count_bound: assert property (@(posedge clock) disable iff (!rst_n)
		count <= rob_cnt_t'(`ROB_SIZE))
		else $error("ROB occupancy count %0d above depth", count);

endmodule

//--- rtl/cdb_pkg.sv
`include "rob_consts.svh"

package cdb_pkg;

	typedef logic [`PREG_W-1:0] preg_t; // Physical tag
	typedef logic [`AREG_W-1:0] areg_t; // Architectural destination

	// Kind of instruction held in a row
	typedef enum logic [1:0] {
		op_alu,
		op_branch, // May carry a mispredict on completion
		op_halt    // Done at dispatch, stops the machine at retire
	} op_kind_t;

endpackage

//--- rtl/rob_pkg.sv
`include "rob_consts.svh"

package rob_pkg;

	// Row pointer, wraps naturally at ROB_SIZE
	typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

	// Occupancy or free row count
	typedef logic [`ROB_CNT_W-1:0] rob_cnt_t;

	// Life of one row
	typedef enum logic [1:0] {
		st_free, // Not allocated
		st_wait, // Waiting for its tag on the CDB
		st_done  // Ready to retire
	} entry_state_t;

endpackage

//--- include/rob_consts.svh
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// Buffer geometry
`define ROB_SIZE 8
`define ROB_IDX_W 3
`define ROB_CNT_W 4 // Holds 0 through ROB_SIZE

// Lanes per cycle for dispatch, CDB and retire
`define SS_WIDTH 2

// Register tag widths
`define PREG_W 6 // 64 physical registers
`define AREG_W 5 // 32 architectural registers

`endif
